/* hdl/cpuPkg.sv */
// shared types and constants for the cut-down 6502 execute core
// only immediate and implied encodings are listed, everything else decodes as illegal
package cpuPkg;

  // byte width of the datapath
  localparam int DATA_W = 8;

  typedef logic [DATA_W-1:0] dataT;

  // kept 6502 encodings, immediate and implied only
  typedef enum logic [7:0] {
    OP_LDA_IMM = 8'hA9,
    OP_LDX_IMM = 8'hA2,
    OP_LDY_IMM = 8'hA0,
    OP_ADC_IMM = 8'h69,
    OP_SBC_IMM = 8'hE9,
    OP_AND_IMM = 8'h29,
    OP_ORA_IMM = 8'h09,
    OP_EOR_IMM = 8'h49,
    OP_LSR_ACC = 8'h4A,
    OP_TAX     = 8'hAA,
    OP_TAY     = 8'hA8,
    OP_TXA     = 8'h8A,
    OP_TYA     = 8'h98,
    OP_INX     = 8'hE8,
    OP_INY     = 8'hC8,
    OP_DEX     = 8'hCA,
    OP_DEY     = 8'h88,
    OP_CLC     = 8'h18,
    OP_SEC     = 8'h38,
    OP_CLD     = 8'hD8,
    OP_SED     = 8'hF8,
    OP_CLV     = 8'hB8
  } opcodeT;

  // alu operations
  typedef enum logic [2:0] {
    ALU_PASS,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHR,
    ALU_FLAG
  } aluOpT;

  // first operand source
  typedef enum logic [1:0] {SRC_ACC, SRC_XREG, SRC_YREG, SRC_OPERAND} srcSelT;

  // register written back
  typedef enum logic [1:0] {DST_NONE, DST_ACC, DST_XREG, DST_YREG} dstSelT;

  // flag field touched by CLC/SEC/CLD/SED/CLV
  localparam logic [1:0] FLAG_SEL_C = 2'd0;
  localparam logic [1:0] FLAG_SEL_D = 2'd1;
  localparam logic [1:0] FLAG_SEL_V = 2'd2;

  // status bit positions
  localparam int STATUS_C = 0;
  localparam int STATUS_Z = 1;
  localparam int STATUS_I = 2;
  localparam int STATUS_D = 3;
  localparam int STATUS_B = 4;
  localparam int STATUS_U = 5;
  localparam int STATUS_V = 6;
  localparam int STATUS_N = 7;

  // bits with a fixed value, I and B stay set since no irq/brk here
  localparam dataT STATUS_FIXED_MASK =
    dataT'((1 << STATUS_U) | (1 << STATUS_B) | (1 << STATUS_I));

  // I, B and bit 5 set, everything else clear
  localparam dataT RESET_STATUS = 8'h34;

endpackage

/* hdl/decimalAdjust.sv */
// packed BCD correction after a binary add or subtract
// output is only meaningful when both original operands were valid BCD
`timescale 1ns/1ps

module decimalAdjust import cpuPkg::*; (
  input  logic [8:0] binSum,
  input  logic       halfCarry,
  input  logic       subtract,
  output dataT       adjusted,
  output logic       decCarry
);

  logic [8:0] lowFixed;
  logic       lowFix;
  logic       highFix;

  always_comb begin
    lowFixed = binSum;
    lowFix   = 1'b0;
    highFix  = 1'b0;
    if (subtract) begin
      // nibble borrow shows as a missing half carry
      lowFix   = !halfCarry;
      highFix  = !binSum[8];
      // low nibble is at least 6 after a borrow, no ripple into high
      adjusted = binSum[7:0] - {(highFix ? 4'h6 : 4'h0), (lowFix ? 4'h6 : 4'h0)};
      // carry is the binary one for SBC
      decCarry = binSum[8];
    end else begin
      lowFix = halfCarry || (binSum[3:0] > 4'd9);
      if (lowFix) begin
        lowFixed = binSum + 9'h006;
      end
      // high digit checked after the low fix rippled in
      highFix  = binSum[8] || (lowFixed[8:4] > 5'd9);
      adjusted = highFix ? (lowFixed[7:0] + 8'h60) : lowFixed[7:0];
      decCarry = highFix;
    end
  end

endmodule

/* hdl/opDecode.sv */
// decodes one strobed opcode per cycle, no back-pressure
// decoded fields hold their value until the next strobe
`timescale 1ns/1ps

module opDecode import cpuPkg::*; (
  input  logic       fastClk,
  input  logic       arstN,
  input  logic       opStrobe,
  input  dataT       opcode,
  input  dataT       operand,
  output logic       opValid,
  output aluOpT      aluOp,
  output srcSelT     srcSel,
  output dstSelT     dstSel,
  output logic       useCarry,
  output logic [1:0] flagWrite,
  output logic       flagValue,
  output dataT       operandReg,
  output logic       illegalOp
);

  aluOpT      decOp;
  srcSelT     decSrc;
  dstSelT     decDst;
  logic       decUseCarry;
  logic [1:0] decFlagWrite;
  logic       decFlagValue;
  logic       decIllegal;

  // opcode to operation, source and destination
  always_comb begin
    decOp        = ALU_PASS;
    decSrc       = SRC_ACC;
    decDst       = DST_NONE;
    decUseCarry  = 1'b0;
    decFlagWrite = FLAG_SEL_C;
    decFlagValue = 1'b0;
    decIllegal   = 1'b0;
    case (opcodeT'(opcode))
      OP_LDA_IMM: begin
        decSrc = SRC_OPERAND;
        decDst = DST_ACC;
      end
      OP_LDX_IMM: begin
        decSrc = SRC_OPERAND;
        decDst = DST_XREG;
      end
      OP_LDY_IMM: begin
        decSrc = SRC_OPERAND;
        decDst = DST_YREG;
      end
      // carry-using arithmetic
      OP_ADC_IMM: begin
        decOp       = ALU_ADD;
        decDst      = DST_ACC;
        decUseCarry = 1'b1;
      end
      OP_SBC_IMM: begin
        decOp       = ALU_SUB;
        decDst      = DST_ACC;
        decUseCarry = 1'b1;
      end
      OP_AND_IMM: begin
        decOp  = ALU_AND;
        decDst = DST_ACC;
      end
      OP_ORA_IMM: begin
        decOp  = ALU_OR;
        decDst = DST_ACC;
      end
      OP_EOR_IMM: begin
        decOp  = ALU_XOR;
        decDst = DST_ACC;
      end
      OP_LSR_ACC: begin
        decOp  = ALU_SHR;
        decDst = DST_ACC;
      end
      // transfers
      OP_TAX: decDst = DST_XREG;
      OP_TAY: decDst = DST_YREG;
      OP_TXA: begin
        decSrc = SRC_XREG;
        decDst = DST_ACC;
      end
      OP_TYA: begin
        decSrc = SRC_YREG;
        decDst = DST_ACC;
      end
      // +-1 without carry in, C untouched
      OP_INX: begin
        decOp  = ALU_ADD;
        decSrc = SRC_XREG;
        decDst = DST_XREG;
      end
      OP_INY: begin
        decOp  = ALU_ADD;
        decSrc = SRC_YREG;
        decDst = DST_YREG;
      end
      OP_DEX: begin
        decOp  = ALU_SUB;
        decSrc = SRC_XREG;
        decDst = DST_XREG;
      end
      OP_DEY: begin
        decOp  = ALU_SUB;
        decSrc = SRC_YREG;
        decDst = DST_YREG;
      end
      // flag set/clear
      OP_CLC: begin
        decOp        = ALU_FLAG;
        decFlagWrite = FLAG_SEL_C;
      end
      OP_SEC: begin
        decOp        = ALU_FLAG;
        decFlagWrite = FLAG_SEL_C;
        decFlagValue = 1'b1;
      end
      OP_CLD: begin
        decOp        = ALU_FLAG;
        decFlagWrite = FLAG_SEL_D;
      end
      OP_SED: begin
        decOp        = ALU_FLAG;
        decFlagWrite = FLAG_SEL_D;
        decFlagValue = 1'b1;
      end
      OP_CLV: begin
        decOp        = ALU_FLAG;
        decFlagWrite = FLAG_SEL_V;
      end
      default: decIllegal = 1'b1;
    endcase
  end

  // control fields
  always_ff @(posedge fastClk or negedge arstN) begin
    if (!arstN) begin
      opValid   <= 1'b0;
      aluOp     <= ALU_PASS;
      srcSel    <= SRC_ACC;
      dstSel    <= DST_NONE;
      useCarry  <= 1'b0;
      flagWrite <= FLAG_SEL_C;
      flagValue <= 1'b0;
      illegalOp <= 1'b0;
    end else begin
      opValid <= opStrobe;
      if (opStrobe) begin
        aluOp     <= decOp;
        srcSel    <= decSrc;
        dstSel    <= decDst;
        useCarry  <= decUseCarry;
        flagWrite <= decFlagWrite;
        flagValue <= decFlagValue;
        illegalOp <= decIllegal;
      end
    end
  end

  // immediate byte
  always_ff @(posedge fastClk or negedge arstN) begin
    if (!arstN) begin
      operandReg <= '0;
    end else if (opStrobe) begin
      operandReg <= operand;
    end
  end

  // a decoded item only follows a sampled strobe
  validFollowsStrobe: assert property (
    @(posedge fastClk) disable iff (!arstN) $rose(opValid) |-> $past(opStrobe)
  ) else $error("opValid rose without a strobe");

endmodule

/* hdl/aluExecute.sv */
// combinational execute stage, reads committed registers only
// decimal mode applies to ADC and SBC, N and V come from the binary result
`timescale 1ns/1ps

module aluExecute import cpuPkg::*; (
  input  logic       opValid,
  input  aluOpT      aluOp,
  input  srcSelT     srcSel,
  input  dstSelT     dstSel,
  input  logic       useCarry,
  input  logic [1:0] flagWrite,
  input  logic       flagValue,
  input  dataT       operandReg,
  input  logic       illegalOp,
  input  dataT       accum,
  input  dataT       xReg,
  input  dataT       yReg,
  input  dataT       status,
  output logic       resultValid,
  output dataT       result,
  output dstSelT     resultDst,
  output dataT       nextStatus,
  output logic       resultIllegal
);

  dataT       opA;
  dataT       opB;
  dataT       addend;
  logic       isArith;
  logic       isSub;
  logic       carryIn;
  logic [4:0] lowSum;
  logic [8:0] binSum;
  logic       binOverflow;
  logic       decMode;
  dataT       decResult;
  logic       decCarry;

  // first operand
  always_comb begin
    case (srcSel)
      SRC_XREG:    opA = xReg;
      SRC_YREG:    opA = yReg;
      SRC_OPERAND: opA = operandReg;
      default:     opA = accum;
    endcase
  end

  assign isArith = (aluOp == ALU_ADD) || (aluOp == ALU_SUB);
  assign isSub   = (aluOp == ALU_SUB);
  // inc/dec add or subtract a constant one
  assign opB     = (isArith && !useCarry) ? dataT'(1) : operandReg;
  assign addend  = isSub ? ~opB : opB;
  // decrement needs the +1 of two's complement
  assign carryIn = useCarry ? status[STATUS_C] : isSub;

  assign lowSum      = {1'b0, opA[3:0]} + {1'b0, addend[3:0]} + 5'(carryIn);
  assign binSum      = {1'b0, opA} + {1'b0, addend} + 9'(carryIn);
  assign binOverflow = (opA[7] == addend[7]) && (binSum[7] != opA[7]);
  assign decMode     = useCarry && status[STATUS_D];

  decimalAdjust decAdj (
    .binSum   (binSum),
    .halfCarry(lowSum[4]),
    .subtract (isSub),
    .adjusted (decResult),
    .decCarry (decCarry)
  );

  always_comb begin
    nextStatus = status;
    result     = opA;
    case (aluOp)
      ALU_ADD, ALU_SUB: begin
        result = decMode ? decResult : binSum[7:0];
        // only ADC/SBC touch C and V
        if (useCarry) begin
          nextStatus[STATUS_C] = decMode ? decCarry : binSum[8];
          nextStatus[STATUS_V] = binOverflow;
        end
      end
      ALU_AND: result = opA & operandReg;
      ALU_OR:  result = opA | operandReg;
      ALU_XOR: result = opA ^ operandReg;
      ALU_SHR: begin
        result               = opA >> 1;
        nextStatus[STATUS_C] = opA[0];
      end
      ALU_FLAG: begin
        case (flagWrite)
          FLAG_SEL_C: nextStatus[STATUS_C] = flagValue;
          FLAG_SEL_D: nextStatus[STATUS_D] = flagValue;
          FLAG_SEL_V: nextStatus[STATUS_V] = flagValue;
          default:    nextStatus = status;
        endcase
      end
      default: result = opA;
    endcase
    if (aluOp != ALU_FLAG) begin
      nextStatus[STATUS_Z] = (result == '0);
      // decimal N taken from the binary sum, SHR gives 0 here
      nextStatus[STATUS_N] = isArith ? binSum[7] : result[7];
    end
  end

  assign resultValid   = opValid;
  assign resultDst     = dstSel;
  assign resultIllegal = illegalOp;

  // an X result would end up in A, X or Y
  always_comb begin
    resultKnown: assert final (!(resultValid && $isunknown(result)))
      else $error("alu result unknown while valid");
  end

endmodule

/* hdl/resultCommit.sv */
// architectural state, written one edge after decode
// illegal items update nothing but still pulse done
`timescale 1ns/1ps

module resultCommit import cpuPkg::*; (
  input  logic   fastClk,
  input  logic   arstN,
  input  logic   resultValid,
  input  dataT   result,
  input  dstSelT resultDst,
  input  dataT   nextStatus,
  input  logic   resultIllegal,
  output dataT   accum,
  output dataT   xReg,
  output dataT   yReg,
  output dataT   status,
  output logic   done,
  output logic   illegal
);

  logic writeEn;

  assign writeEn = resultValid && !resultIllegal;

  // A, X, Y and P
  always_ff @(posedge fastClk or negedge arstN) begin
    if (!arstN) begin
      accum  <= '0;
      xReg   <= '0;
      yReg   <= '0;
      status <= RESET_STATUS;
    end else if (writeEn) begin
      case (resultDst)
        DST_ACC:  accum <= result;
        DST_XREG: xReg  <= result;
        DST_YREG: yReg  <= result;
        default:  accum <= accum;
      endcase
      // bits 5, 4, 2 pinned to their reset values
      status <= (nextStatus & ~STATUS_FIXED_MASK) | (RESET_STATUS & STATUS_FIXED_MASK);
    end
  end

  // completion pulses, one per item
  always_ff @(posedge fastClk or negedge arstN) begin
    if (!arstN) begin
      done    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      done    <= resultValid;
      illegal <= resultValid && resultIllegal;
    end
  end

  // every done pulse matches one executed item
  doneHasItem: assert property (
    @(posedge fastClk) disable iff (!arstN) done |-> $past(resultValid)
  ) else $error("done without a matching result");

endmodule

/* hdl/cpuCore.sv */
// execute core top, two edges from a sampled strobe to state and done
// no forwarding, execute always sees the last committed registers
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
  input  logic fastClk,
  input  logic arstN,
  input  logic opStrobe,
  input  dataT opcode,
  input  dataT operand,
  output dataT accum,
  output dataT xReg,
  output dataT yReg,
  output dataT status,
  output logic done,
  output logic illegal
);

  // decode to execute
  logic       opValid;
  aluOpT      aluOp;
  srcSelT     srcSel;
  dstSelT     dstSel;
  logic       useCarry;
  logic [1:0] flagWrite;
  logic       flagValue;
  dataT       operandReg;
  logic       illegalOp;

  // execute to commit
  logic       resultValid;
  dataT       result;
  dstSelT     resultDst;
  dataT       nextStatus;
  logic       resultIllegal;

  opDecode decode (
    .fastClk, .arstN, .opStrobe, .opcode, .operand,
    .opValid, .aluOp, .srcSel, .dstSel, .useCarry,
    .flagWrite, .flagValue, .operandReg, .illegalOp
  );

  aluExecute execute (
    .opValid, .aluOp, .srcSel, .dstSel, .useCarry, .flagWrite, .flagValue,
    .operandReg, .illegalOp, .accum, .xReg, .yReg, .status,
    .resultValid, .result, .resultDst, .nextStatus, .resultIllegal
  );

  resultCommit commit (
    .fastClk, .arstN, .resultValid, .result, .resultDst, .nextStatus,
    .resultIllegal, .accum, .xReg, .yReg, .status, .done, .illegal
  );

endmodule

/* dv/cpuCoreTb.sv */
// table-driven testbench, one instruction in flight per entry plus one back-to-back burst
// decimal entries only ever use valid BCD operands
`timescale 1ns/1ps

module cpuCoreTb import cpuPkg::*; ();

  logic fastClk = 1'b0;
  logic arstN;
  logic opStrobe;
  dataT opcode;
  dataT operand;
  dataT accum;
  dataT xReg;
  dataT yReg;
  dataT status;
  logic done;
  logic illegal;

  // stimulus table, expected values are literal or filled by the model
  string tName [0:95];
  dataT  tOp [0:95];
  dataT  tOpnd [0:95];
  logic  tUseModel [0:95];
  logic  tIll [0:95];
  dataT  tA [0:95];
  dataT  tX [0:95];
  dataT  tY [0:95];
  dataT  tP [0:95];
  int    nEntries = 0;

  // model state
  dataT mA;
  dataT mX;
  dataT mY;
  dataT mP;

  int seed = 32'ha7c5_7e2f;
  int timeoutCycles = 20;
  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int doneCount = 0;

  cpuCore dut (
    .fastClk, .arstN, .opStrobe, .opcode, .operand,
    .accum, .xReg, .yReg, .status, .done, .illegal
  );

  always #2 fastClk = ~fastClk;

  // done is stable at the falling edge
  always @(negedge fastClk) begin
    if (done) begin
      doneCount++;
    end
  end

  function automatic string flagText(dataT p);
    string letters;
    string s;
    letters = "NV1BDIZC";
    s = "";
    for (int i = 7; i >= 0; i--) begin
      if (p[i]) s = {s, letters.substr(7 - i, 7 - i)};
      else s = {s, "."};
    end
    return s;
  endfunction

  task automatic checkByte(input string name, input string what, input dataT exp, input dataT act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s %s expected %02h actual %02h", name, what, exp, act);
    end
  endtask

  task automatic checkStatus(input string name, input dataT exp, input dataT act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s status expected %02h (%s) actual %02h (%s)",
               name, exp, flagText(exp), act, flagText(act));
    end
  endtask

  task automatic checkPulse(input string name, input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s %s expected %0b actual %0b", name, what, exp, act);
    end
  endtask

  function automatic dataT randByte();
    return dataT'($random(seed));
  endfunction

  // two random decimal digits
  function automatic dataT randBcd();
    dataT b;
    b[7:4] = $unsigned($random(seed)) % 10;
    b[3:0] = $unsigned($random(seed)) % 10;
    return b;
  endfunction

  function automatic int bcdToInt(dataT b);
    return b[7:4] * 10 + b[3:0];
  endfunction

  function automatic dataT intToBcd(int v);
    dataT b;
    b[7:4] = v / 10;
    b[3:0] = v % 10;
    return b;
  endfunction

  task automatic addEntry(input string name, input dataT op, input dataT opnd, input logic ill,
                          input dataT a, input dataT x, input dataT y, input dataT p);
    tName[nEntries] = name;
    tOp[nEntries] = op;
    tOpnd[nEntries] = opnd;
    tUseModel[nEntries] = 1'b0;
    tIll[nEntries] = ill;
    tA[nEntries] = a;
    tX[nEntries] = x;
    tY[nEntries] = y;
    tP[nEntries] = p;
    nEntries++;
  endtask

  task automatic addModel(input string name, input dataT op, input dataT opnd);
    addEntry(name, op, opnd, 1'b0, '0, '0, '0, '0);
    tUseModel[nEntries - 1] = 1'b1;
  endtask

  // expected architectural effect of one instruction
  task automatic modelStep(input dataT op, input dataT opnd);
    dataT r;
    dataT m;
    logic [8:0] wide;
    logic setNZ;
    int sum;
    int signedSum;
    r = '0;
    setNZ = 1'b1;
    case (op)
      OP_LDA_IMM: begin
        mA = opnd;
        r = mA;
      end
      OP_LDX_IMM: begin
        mX = opnd;
        r = mX;
      end
      OP_LDY_IMM: begin
        mY = opnd;
        r = mY;
      end
      OP_ADC_IMM, OP_SBC_IMM: begin
        // subtract is A plus the complement of M plus C
        m = (op == OP_SBC_IMM) ? ~opnd : opnd;
        wide = mA + m + mP[STATUS_C];
        // overflow when the signed sum leaves -128..127
        signedSum = int'($signed(mA)) + int'($signed(m)) + int'(mP[STATUS_C]);
        mP[STATUS_V] = (signedSum > 127) || (signedSum < -128);
        mP[STATUS_N] = wide[7];
        if (mP[STATUS_D] && op == OP_ADC_IMM) begin
          sum = bcdToInt(mA) + bcdToInt(opnd) + mP[STATUS_C];
          mP[STATUS_C] = (sum > 99);
          r = intToBcd(sum % 100);
        end else if (mP[STATUS_D]) begin
          sum = bcdToInt(mA) - bcdToInt(opnd) - (1 - mP[STATUS_C]);
          mP[STATUS_C] = (sum >= 0);
          r = intToBcd((sum + 100) % 100);
        end else begin
          r = wide[7:0];
          mP[STATUS_C] = wide[8];
        end
        mP[STATUS_Z] = (r == 8'h00);
        mA = r;
        setNZ = 1'b0;
      end
      OP_AND_IMM: begin
        mA = mA & opnd;
        r = mA;
      end
      OP_ORA_IMM: begin
        mA = mA | opnd;
        r = mA;
      end
      OP_EOR_IMM: begin
        mA = mA ^ opnd;
        r = mA;
      end
      OP_LSR_ACC: begin
        mP[STATUS_C] = mA[0];
        mA = mA >> 1;
        r = mA;
      end
      OP_TAX: begin
        mX = mA;
        r = mX;
      end
      OP_TAY: begin
        mY = mA;
        r = mY;
      end
      OP_TXA: begin
        mA = mX;
        r = mA;
      end
      OP_TYA: begin
        mA = mY;
        r = mA;
      end
      OP_INX: begin
        mX = mX + 1;
        r = mX;
      end
      OP_INY: begin
        mY = mY + 1;
        r = mY;
      end
      OP_DEX: begin
        mX = mX - 1;
        r = mX;
      end
      OP_DEY: begin
        mY = mY - 1;
        r = mY;
      end
      OP_CLC: begin
        mP[STATUS_C] = 1'b0;
        setNZ = 1'b0;
      end
      OP_SEC: begin
        mP[STATUS_C] = 1'b1;
        setNZ = 1'b0;
      end
      OP_CLD: begin
        mP[STATUS_D] = 1'b0;
        setNZ = 1'b0;
      end
      OP_SED: begin
        mP[STATUS_D] = 1'b1;
        setNZ = 1'b0;
      end
      OP_CLV: begin
        mP[STATUS_V] = 1'b0;
        setNZ = 1'b0;
      end
      // unknown opcode leaves the state alone
      default: setNZ = 1'b0;
    endcase
    if (setNZ) begin
      mP[STATUS_Z] = (r == 8'h00);
      mP[STATUS_N] = r[7];
    end
  endtask

  task automatic runEntry(input int i);
    int waited;
    @(negedge fastClk);
    opcode = tOp[i];
    operand = tOpnd[i];
    opStrobe = 1'b1;
    @(negedge fastClk);
    opStrobe = 1'b0;
    modelStep(tOp[i], tOpnd[i]);
    if (!tUseModel[i]) begin
      // literal values win, the model follows them
      mA = tA[i];
      mX = tX[i];
      mY = tY[i];
      mP = tP[i];
    end
    waited = 0;
    while (!done && waited < timeoutCycles) begin
      @(negedge fastClk);
      waited++;
    end
    if (!done) begin
      timeouts++;
      $display("%s never signalled done within %0d cycles", tName[i], timeoutCycles);
    end else begin
      checkByte(tName[i], "A", mA, accum);
      checkByte(tName[i], "X", mX, xReg);
      checkByte(tName[i], "Y", mY, yReg);
      checkStatus(tName[i], mP, status);
      checkPulse(tName[i], "illegal", tIll[i], illegal);
    end
  endtask

  // three strobes on consecutive cycles, each reads the previous commit
  task automatic runBurst();
    int startCount;
    int waited;
    @(negedge fastClk);
    // done is low here, so the count is settled
    startCount = doneCount;
    opcode = OP_LDX_IMM;
    operand = 8'h05;
    opStrobe = 1'b1;
    @(negedge fastClk);
    opcode = OP_INX;
    @(negedge fastClk);
    opcode = OP_TXA;
    @(negedge fastClk);
    opStrobe = 1'b0;
    waited = 0;
    while (doneCount - startCount < 3 && waited < timeoutCycles) begin
      @(negedge fastClk);
      waited++;
    end
    // a couple of idle cycles to catch any extra pulse
    repeat (2) @(negedge fastClk);
    if (doneCount - startCount != 3) begin
      timeouts++;
      $display("burst produced %0d done pulses instead of 3", doneCount - startCount);
    end
    checkByte("burst", "A", 8'h06, accum);
    checkByte("burst", "X", 8'h06, xReg);
    checkByte("burst", "Y", 8'h00, yReg);
    checkStatus("burst", 8'h34, status);
  endtask

  initial begin
    arstN = 1'b0;
    opStrobe = 1'b0;
    opcode = '0;
    operand = '0;
    mA = '0;
    mX = '0;
    mY = '0;
    mP = RESET_STATUS;

    // loads, transfers, inc and dec
    addEntry("ldaZero", OP_LDA_IMM, 8'h00, 1'b0, 8'h00, 8'h00, 8'h00, 8'h36);
    addEntry("ldaNeg", OP_LDA_IMM, 8'h80, 1'b0, 8'h80, 8'h00, 8'h00, 8'hB4);
    addEntry("ldxFF", OP_LDX_IMM, 8'hFF, 1'b0, 8'h80, 8'hFF, 8'h00, 8'hB4);
    addEntry("inxWrap", OP_INX, 8'h00, 1'b0, 8'h80, 8'h00, 8'h00, 8'h36);
    addEntry("dexWrap", OP_DEX, 8'h00, 1'b0, 8'h80, 8'hFF, 8'h00, 8'hB4);
    addEntry("tax", OP_TAX, 8'h00, 1'b0, 8'h80, 8'h80, 8'h00, 8'hB4);
    addEntry("ldy", OP_LDY_IMM, 8'h01, 1'b0, 8'h80, 8'h80, 8'h01, 8'h34);
    addEntry("dey", OP_DEY, 8'h00, 1'b0, 8'h80, 8'h80, 8'h00, 8'h36);
    addEntry("tya", OP_TYA, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h36);
    addEntry("iny", OP_INY, 8'h00, 1'b0, 8'h00, 8'h80, 8'h01, 8'h34);
    addEntry("tay", OP_TAY, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h36);
    addEntry("txa", OP_TXA, 8'h00, 1'b0, 8'h80, 8'h80, 8'h00, 8'hB4);
    addEntry("clcBin", OP_CLC, 8'h00, 1'b0, 8'h80, 8'h80, 8'h00, 8'hB4);
    // binary arithmetic on random operands
    for (int k = 0; k < 6; k++) begin
      addModel($sformatf("binLda%0d", k), OP_LDA_IMM, randByte());
      addModel($sformatf("binAdc%0d", k), OP_ADC_IMM, randByte());
      addModel($sformatf("binSbc%0d", k), OP_SBC_IMM, randByte());
    end
    addModel("clcPrep", OP_CLC, 8'h00);
    addModel("clvPrep", OP_CLV, 8'h00);
    // decimal mode, 58 + 46 wraps to 04 with carry
    addEntry("ldaBcd", OP_LDA_IMM, 8'h58, 1'b0, 8'h58, 8'h80, 8'h00, 8'h34);
    addEntry("sed", OP_SED, 8'h00, 1'b0, 8'h58, 8'h80, 8'h00, 8'h3C);
    addEntry("adcDec", OP_ADC_IMM, 8'h46, 1'b0, 8'h04, 8'h80, 8'h00, 8'hFD);
    addEntry("sbcDec", OP_SBC_IMM, 8'h02, 1'b0, 8'h02, 8'h80, 8'h00, 8'h3D);
    addEntry("sbcBorrow", OP_SBC_IMM, 8'h05, 1'b0, 8'h97, 8'h80, 8'h00, 8'hBC);
    for (int k = 0; k < 4; k++) begin
      addModel($sformatf("decLda%0d", k), OP_LDA_IMM, randBcd());
      addModel($sformatf("decAdc%0d", k), OP_ADC_IMM, randBcd());
      addModel($sformatf("decSbc%0d", k), OP_SBC_IMM, randBcd());
    end
    // back to binary
    addModel("cld", OP_CLD, 8'h00);
    addModel("clcAfter", OP_CLC, 8'h00);
    addModel("clvAfter", OP_CLV, 8'h00);
    addEntry("ldaBin", OP_LDA_IMM, 8'h58, 1'b0, 8'h58, 8'h80, 8'h00, 8'h34);
    addEntry("adcBin", OP_ADC_IMM, 8'h46, 1'b0, 8'h9E, 8'h80, 8'h00, 8'hF4);
    // logic, shift and flag instructions
    addEntry("andImm", OP_AND_IMM, 8'h0F, 1'b0, 8'h0E, 8'h80, 8'h00, 8'h74);
    addEntry("oraImm", OP_ORA_IMM, 8'hF0, 1'b0, 8'hFE, 8'h80, 8'h00, 8'hF4);
    addEntry("eorImm", OP_EOR_IMM, 8'hFE, 1'b0, 8'h00, 8'h80, 8'h00, 8'h76);
    addEntry("ldaOdd", OP_LDA_IMM, 8'h03, 1'b0, 8'h03, 8'h80, 8'h00, 8'h74);
    addEntry("lsrOdd", OP_LSR_ACC, 8'h00, 1'b0, 8'h01, 8'h80, 8'h00, 8'h75);
    addEntry("lsrToZero", OP_LSR_ACC, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h77);
    addEntry("lsrZero", OP_LSR_ACC, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h76);
    addEntry("sec", OP_SEC, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h77);
    addEntry("clv", OP_CLV, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h37);
    addEntry("sedOnly", OP_SED, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h3F);
    addEntry("cldOnly", OP_CLD, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h37);
    addEntry("clc", OP_CLC, 8'h00, 1'b0, 8'h00, 8'h80, 8'h00, 8'h36);
    // unknown opcodes change nothing
    addEntry("illegal02", 8'h02, 8'h55, 1'b1, 8'h00, 8'h80, 8'h00, 8'h36);
    addEntry("illegalFF", 8'hFF, 8'hAA, 1'b1, 8'h00, 8'h80, 8'h00, 8'h36);

    repeat (5) @(negedge fastClk);
    arstN = 1'b1;
    repeat (2) @(negedge fastClk);
    checkByte("reset", "A", 8'h00, accum);
    checkByte("reset", "X", 8'h00, xReg);
    checkByte("reset", "Y", 8'h00, yReg);
    checkStatus("reset", 8'h34, status);
    checkPulse("reset", "done", 1'b0, done);
    checkPulse("reset", "illegal", 1'b0, illegal);
    if (doneCount != 0) begin
      errors++;
      $display("done pulsed during or right after reset");
    end

    for (int i = 0; i < nEntries; i++) begin
      runEntry(i);
    end
    runBurst();

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* cpuCore.f */
hdl/cpuPkg.sv
hdl/decimalAdjust.sv
hdl/opDecode.sv
hdl/aluExecute.sv
hdl/resultCommit.sv
hdl/cpuCore.sv
dv/cpuCoreTb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - hdl/cpuPkg.sv
  - hdl/decimalAdjust.sv
  - hdl/opDecode.sv
  - hdl/aluExecute.sv
  - hdl/resultCommit.sv
  - hdl/cpuCore.sv
  - target: test
    files:
      - dv/cpuCoreTb.sv
